/* Makefile */
# Verilator build and run of the AXI4 read register slice testbench

VERILATOR ?= verilator
TOP       ?= axi_register_rd_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
source/axi_rd_proto_pkg.sv
source/axi_rd_cfg_pkg.sv
source/axi_ar_reg.sv
source/axi_r_skid.sv
source/axi_register_rd.sv
dv/tb_clk_gen.sv
dv/axi_register_rd_props.sv
dv/axi_register_rd_tb.sv

/* dv/axi_register_rd_props.sv */
// handshake stability and ready rules for the read slices, bound into each slice
`timescale 1ns/1ps

module axi_register_rd_props
    import axi_rd_cfg_pkg::*;
#(
    parameter int PAY_W = 1
) (
    input logic             clk,
    input logic             rst,
    input logic             out_valid,
    input logic             out_ready,
    input logic [PAY_W-1:0] out_payload,
    input logic             in_ready,
    input skid_state_t      skid_state,
    input logic             skid_ready
);

    // a stalled output keeps valid and payload
    stall_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_payload))
        else $error("output valid or payload changed while stalled");

    // no new request while the output register is held
    held_blocks_input: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |-> !in_ready)
        else $error("input ready high while the output is held");

    // full skid buffer closes the input
    full_skid_closed: assert property (@(posedge clk) disable iff (rst)
        skid_state == skid_two |-> !skid_ready)
        else $error("skid buffer full with m_rready high");

endmodule

bind axi_ar_reg axi_register_rd_props #(
    .PAY_W (ID_WIDTH + ADDR_WIDTH + LEN_W + SIZE_W + $bits(burst_t) + 1 +
            CACHE_W + PROT_W + QOS_W + REGION_W)
) ar_props_i (
    .clk         (clk),
    .rst         (rst),
    .out_valid   (m_arvalid),
    .out_ready   (m_arready),
    .out_payload ({m_arid, m_araddr, m_arlen, m_arsize, m_arburst, m_arlock,
                   m_arcache, m_arprot, m_arqos, m_arregion}),
    .in_ready    (s_arready),
    .skid_state  (skid_empty),
    .skid_ready  (1'b0)
);

bind axi_r_skid axi_register_rd_props #(
    .PAY_W (ID_WIDTH + DATA_WIDTH + $bits(resp_t) + 1)
) r_props_i (
    .clk         (clk),
    .rst         (rst),
    .out_valid   (s_rvalid),
    .out_ready   (s_rready),
    .out_payload ({s_rid, s_rdata, s_rresp, s_rlast}),
    .in_ready    (1'b0),
    .skid_state  (state),
    .skid_ready  (m_rready)
);

/* dv/axi_register_rd_tb.sv */
// testbench for the AXI4 read register slice, table stimulus with in-order scoreboards
`timescale 1ns/1ps

module axi_register_rd_tb
    import axi_rd_proto_pkg::*;
    import axi_rd_cfg_pkg::*;
();

    localparam int ID_W    = DEF_ID_W;
    localparam int ADDR_W  = DEF_ADDR_W;
    localparam int DATA_W  = DEF_DATA_W;
    localparam int SIDE_W  = SIZE_W + 1 + CACHE_W + PROT_W + QOS_W + REGION_W;
    localparam int AR_N    = 5;
    localparam int R_N     = 6;
    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        burst_t            burst;
    } ar_entry_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_t             resp;
        logic              last;
    } r_entry_t;

    // id, addr, len, burst
    ar_entry_t ar_table [AR_N] = '{
        '{8'h01, 32'h0000_1000, 8'h00, burst_incr},
        '{8'h7e, 32'h8004_a5c0, 8'h0f, burst_wrap},
        '{8'hc3, 32'hdead_beef, 8'hff, burst_fixed},
        '{8'hff, 32'hffff_fffc, 8'h07, burst_incr},
        '{8'h5a, 32'h1237_3a78, 8'h01, burst_wrap}
    };

    // id, data, resp, last
    r_entry_t r_table [R_N] = '{
        '{8'h10, 32'hcafe_0000, resp_okay, 1'b0},
        '{8'h10, 32'hcafe_0001, resp_exokay, 1'b1},
        '{8'h22, 32'h0000_0000, resp_slverr, 1'b1},
        '{8'hf0, 32'hffff_ffff, resp_decerr, 1'b0},
        '{8'hf0, 32'h5555_aaaa, resp_okay, 1'b1},
        '{8'h01, 32'h1357_9bdf, resp_exokay, 1'b1}
    };

    logic [ID_W-1:0]     s_arid, m_arid, s_rid, m_rid;
    logic [ADDR_W-1:0]   s_araddr, m_araddr;
    logic [LEN_W-1:0]    s_arlen, m_arlen;
    logic [SIZE_W-1:0]   s_arsize, m_arsize;
    logic [CACHE_W-1:0]  s_arcache, m_arcache;
    logic [PROT_W-1:0]   s_arprot, m_arprot;
    logic [QOS_W-1:0]    s_arqos, m_arqos;
    logic [REGION_W-1:0] s_arregion, m_arregion;
    logic [DATA_W-1:0]   s_rdata, m_rdata;
    burst_t              s_arburst, m_arburst;
    resp_t               s_rresp, m_rresp;
    logic                clk, rst, s_arlock, m_arlock, s_rlast, m_rlast;
    logic                s_arvalid, s_arready, m_arvalid, s_rvalid, m_rvalid, m_rready;
    logic                m_arready = 1'b1;
    logic                s_rready = 1'b1;

    integer seed = 32'h2d97_a9a3;
    integer rnd;
    bit     random_mode = 1'b0;
    int     cycle = 0;
    int     wait_cnt;
    int     ar_out_cnt = 0;
    int     r_out_cnt = 0;
    int     ar_last_in = -1;
    int     r_last_in = -1;
    // acceptance cycle of every transfer still inside the DUT
    int     ar_stamps [$];
    int     r_stamps [$];

    tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

    axi_register_rd dut_i (.*);

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_ctrl(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: s_arready m_arvalid s_rvalid m_rready = %b, expected %b",
                $time, got, exp));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    // opaque fields carry the low address bits of their request
    task automatic check_ar(input ar_entry_t exp);
        if ({m_arid, m_araddr, m_arlen, m_arburst} !== exp ||
            {m_arsize, m_arlock, m_arcache, m_arprot, m_arqos, m_arregion} !==
            exp.addr[SIDE_W-1:0]) begin
            stop_run($sformatf("Error at %0t: request id %h addr %h len %h burst %s, %s%h %h %h %s",
                $time, m_arid, m_araddr, m_arlen, m_arburst.name(), "expected ",
                exp.id, exp.addr, exp.len, exp.burst.name()));
        end
    endtask

    task automatic check_r(input r_entry_t exp);
        if ({s_rid, s_rdata, s_rresp, s_rlast} !== exp) begin
            stop_run($sformatf("Error at %0t: beat id %h data %h resp %s last %b, %s%h %h %s %b",
                $time, s_rid, s_rdata, s_rresp.name(), s_rlast, "expected ",
                exp.id, exp.data, exp.resp.name(), exp.last));
        end
    endtask

    // waits for the DUT to take the request or beat now on its inputs
    task automatic await_accept(input bit on_ar);
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) begin
                stop_run(on_ar ? "s_arready never rose, request stuck" :
                                 "m_rready never rose, beat stuck");
            end
        end while (on_ar ? !s_arready : !m_rready);
    endtask

    task automatic drive_ar();
        int i;
        for (i = 0; i < AR_N; i++) begin
            @(negedge clk);
            s_arvalid = 1'b1;
            {s_arid, s_araddr, s_arlen} = {ar_table[i].id, ar_table[i].addr, ar_table[i].len};
            s_arburst = ar_table[i].burst;
            {s_arsize, s_arlock, s_arcache, s_arprot, s_arqos, s_arregion} =
                ar_table[i].addr[SIDE_W-1:0];
            await_accept(1'b1);
        end
        @(negedge clk);
        s_arvalid = 1'b0;
    endtask

    task automatic drive_r();
        int i;
        for (i = 0; i < R_N; i++) begin
            @(negedge clk);
            m_rvalid = 1'b1;
            {m_rid, m_rdata, m_rlast} = {r_table[i].id, r_table[i].data, r_table[i].last};
            m_rresp = r_table[i].resp;
            await_accept(1'b0);
        end
        @(negedge clk);
        m_rvalid = 1'b0;
    endtask

    task automatic wait_drained(input int ar_exp, input int r_exp);
        wait_cnt = 0;
        while (ar_out_cnt != ar_exp || r_out_cnt != r_exp) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                stop_run("outputs did not drain, transfers missing");
            end
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // scoreboards, with exact latency and spacing while the ready inputs stay high
    always @(posedge clk) begin
        if (!rst && m_arvalid && m_arready) begin
            if (ar_stamps.size() == 0) begin
                stop_run("a request left the DUT that was never accepted");
            end
            check_ar(ar_table[ar_out_cnt % AR_N]);
            if (!random_mode) begin
                check_count("request latency", cycle - ar_stamps[0], 1);
            end
            void'(ar_stamps.pop_front());
            ar_out_cnt++;
        end
        if (!rst && s_arvalid && s_arready) begin
            if (!random_mode && ar_last_in >= 0) begin
                check_count("request spacing", cycle - ar_last_in, 2);
            end
            ar_stamps.push_back(cycle);
            ar_last_in = cycle;
        end
        if (!rst && s_rvalid && s_rready) begin
            if (r_stamps.size() == 0) begin
                stop_run("a beat left the DUT that was never accepted");
            end
            check_r(r_table[r_out_cnt % R_N]);
            if (!random_mode) begin
                check_count("beat latency", cycle - r_stamps[0], 1);
            end
            void'(r_stamps.pop_front());
            r_out_cnt++;
        end
        if (!rst && m_rvalid && m_rready) begin
            if (!random_mode && r_last_in >= 0) begin
                check_count("beat spacing", cycle - r_last_in, 1);
            end
            r_stamps.push_back(cycle);
            r_last_in = cycle;
        end
    end

    always @(negedge clk) begin
        if (random_mode) begin
            rnd = $random(seed);
            m_arready = rnd[0];
            // upstream takes about three beats in four
            s_rready = rnd[1] | rnd[2];
        end
    end

    initial begin
        s_arvalid = 1'b0;
        {s_arid, s_araddr, s_arlen, s_arsize} = '0;
        {s_arlock, s_arcache, s_arprot, s_arqos, s_arregion} = '0;
        s_arburst = burst_fixed;
        m_rvalid = 1'b0;
        {m_rid, m_rdata, m_rlast} = '0;
        m_rresp = resp_okay;

        // all low through reset and the cycle after release
        wait_cnt = 0;
        do begin
            @(negedge clk);
            if (rst) begin
                check_ctrl({s_arready, m_arvalid, s_rvalid, m_rready}, 4'b0000);
            end
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                stop_run("reset was never released");
            end
        end while (rst);
        check_ctrl({s_arready, m_arvalid, s_rvalid, m_rready}, 4'b1001);

        // full rate pass, both ready inputs held high
        fork
            drive_ar();
            drive_r();
        join
        wait_drained(AR_N, R_N);

        // same tables again under random stalls
        #1 random_mode = 1'b1;
        fork
            drive_ar();
            drive_r();
        join
        wait_drained(2 * AR_N, 2 * R_N);

        // a few idle cycles so a stray extra transfer still reaches the scoreboards
        repeat (4) @(negedge clk);

        $display("sim passed");
        $finish;
    end

endmodule

/* dv/tb_clk_gen.sv */
// testbench clock and reset source, 10 ns period with reset held for 16 cycles
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset drops on a falling edge so the DUT sees it cleanly on the next rise
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
    end

endmodule

/* source/axi_ar_reg.sv */
// read-address slice holding one request in an output register, bubble between requests
`timescale 1ns/1ps

module axi_ar_reg
    import axi_rd_proto_pkg::*;
    import axi_rd_cfg_pkg::*;
#(
    parameter int ADDR_WIDTH = DEF_ADDR_W,
    parameter int ID_WIDTH   = DEF_ID_W
) (
    input  logic                  clk,
    input  logic                  rst,

    // upstream request
    input  logic [ID_WIDTH-1:0]   s_arid,
    input  logic [ADDR_WIDTH-1:0] s_araddr,
    input  logic [LEN_W-1:0]      s_arlen,
    input  logic [SIZE_W-1:0]     s_arsize,
    input  burst_t                s_arburst,
    input  logic                  s_arlock,
    input  logic [CACHE_W-1:0]    s_arcache,
    input  logic [PROT_W-1:0]     s_arprot,
    input  logic [QOS_W-1:0]      s_arqos,
    input  logic [REGION_W-1:0]   s_arregion,
    input  logic                  s_arvalid,
    output logic                  s_arready,

    // downstream request
    output logic [ID_WIDTH-1:0]   m_arid,
    output logic [ADDR_WIDTH-1:0] m_araddr,
    output logic [LEN_W-1:0]      m_arlen,
    output logic [SIZE_W-1:0]     m_arsize,
    output burst_t                m_arburst,
    output logic                  m_arlock,
    output logic [CACHE_W-1:0]    m_arcache,
    output logic [PROT_W-1:0]     m_arprot,
    output logic [QOS_W-1:0]      m_arqos,
    output logic [REGION_W-1:0]   m_arregion,
    output logic                  m_arvalid,
    input  logic                  m_arready
);

    logic arvalid_next;
    logic store_in;

    // s_arready high means the output register is empty, so loading never overwrites
    always_comb begin
        arvalid_next = m_arvalid;
        store_in     = 1'b0;
        if (s_arready) begin
            arvalid_next = s_arvalid;
            store_in     = s_arvalid;
        end else if (m_arready) begin
            arvalid_next = 1'b0;
        end
    end

    // ready for next cycle only if the slot will be empty
    always_ff @(posedge clk) begin
        if (rst) begin
            m_arvalid <= 1'b0;
            s_arready <= 1'b0;
        end else begin
            m_arvalid <= arvalid_next;
            s_arready <= !arvalid_next;
        end
    end

    // request payload, opaque fields pass through as is
    always_ff @(posedge clk) begin
        if (store_in) begin
            m_arid     <= s_arid;
            m_araddr   <= s_araddr;
            m_arlen    <= s_arlen;
            m_arsize   <= s_arsize;
            m_arburst  <= s_arburst;
            m_arlock   <= s_arlock;
            m_arcache  <= s_arcache;
            m_arprot   <= s_arprot;
            m_arqos    <= s_arqos;
            m_arregion <= s_arregion;
        end
    end

endmodule

/* source/axi_r_skid.sv */
// read-data skid buffer with an output and a skid entry, full throughput under back-pressure
`timescale 1ns/1ps

module axi_r_skid
    import axi_rd_proto_pkg::*;
    import axi_rd_cfg_pkg::*;
#(
    parameter int DATA_WIDTH = DEF_DATA_W,
    parameter int ID_WIDTH   = DEF_ID_W
) (
    input  logic                  clk,
    input  logic                  rst,

    // beats from the downstream subordinate
    input  logic [ID_WIDTH-1:0]   m_rid,
    input  logic [DATA_WIDTH-1:0] m_rdata,
    input  resp_t                 m_rresp,
    input  logic                  m_rlast,
    input  logic                  m_rvalid,
    output logic                  m_rready,

    // beats to the upstream manager
    output logic [ID_WIDTH-1:0]   s_rid,
    output logic [DATA_WIDTH-1:0] s_rdata,
    output resp_t                 s_rresp,
    output logic                  s_rlast,
    output logic                  s_rvalid,
    input  logic                  s_rready
);

    skid_state_t state;
    skid_state_t state_next;
    logic        rready_next;
    logic        store_in_to_out;
    logic        store_in_to_skid;
    logic        store_skid_to_out;

    // skid entry payload
    logic [ID_WIDTH-1:0]   skid_rid;
    logic [DATA_WIDTH-1:0] skid_rdata;
    resp_t                 skid_rresp;
    logic                  skid_rlast;

    assign s_rvalid = (state != skid_empty);

    // drop ready only when a stalled output could push a beat into the skid entry
    assign rready_next = s_rready || (state == skid_empty) ||
                         ((state == skid_one) && !m_rvalid);

    always_comb begin
        state_next        = state;
        store_in_to_out   = 1'b0;
        store_in_to_skid  = 1'b0;
        store_skid_to_out = 1'b0;
        if (m_rready) begin
            // m_rready high implies the skid entry is free
            if (s_rready || state == skid_empty) begin
                store_in_to_out = m_rvalid;
                state_next      = m_rvalid ? skid_one : skid_empty;
            end else begin
                store_in_to_skid = m_rvalid;
                state_next       = m_rvalid ? skid_two : skid_one;
            end
        end else if (s_rready) begin
            // input closed, drain one entry
            case (state)
                skid_two: begin
                    store_skid_to_out = 1'b1;
                    state_next        = skid_one;
                end
                default: begin
                    state_next = skid_empty;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= skid_empty;
            m_rready <= 1'b0;
        end else begin
            state    <= state_next;
            m_rready <= rready_next;
        end
    end

    // output register, loaded from input or from skid
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            s_rid   <= m_rid;
            s_rdata <= m_rdata;
            s_rresp <= m_rresp;
            s_rlast <= m_rlast;
        end else if (store_skid_to_out) begin
            s_rid   <= skid_rid;
            s_rdata <= skid_rdata;
            s_rresp <= skid_rresp;
            s_rlast <= skid_rlast;
        end
    end

    // skid register
    always_ff @(posedge clk) begin
        if (store_in_to_skid) begin
            skid_rid   <= m_rid;
            skid_rdata <= m_rdata;
            skid_rresp <= m_rresp;
            skid_rlast <= m_rlast;
        end
    end

endmodule

/* source/axi_rd_cfg_pkg.sv */
// read register slice configuration with default bus widths and skid buffer state type
package axi_rd_cfg_pkg;

    // default bus widths, overridden from the top level
    localparam int DEF_DATA_W = 32;
    localparam int DEF_ADDR_W = 32;
    localparam int DEF_ID_W   = 8;

    // occupancy of the two-entry skid buffer
    // one means only the output register holds a beat
    typedef enum logic [1:0] {
        skid_empty = 2'b00,
        skid_one   = 2'b01,
        skid_two   = 2'b10
    } skid_state_t;

endpackage

/* source/axi_rd_proto_pkg.sv */
// AXI4 read-path protocol definitions with fixed field widths and channel encodings
package axi_rd_proto_pkg;

    // fixed AXI4 address channel field widths
    localparam int LEN_W    = 8;
    localparam int SIZE_W   = 3;
    localparam int CACHE_W  = 4;
    localparam int PROT_W   = 3;
    localparam int QOS_W    = 4;
    localparam int REGION_W = 4;

    // arburst encoding
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } burst_t;

    // rresp encoding
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_t;

endpackage

/* source/axi_register_rd.sv */
// AXI4 read register slice joining an address register and a data skid buffer
`timescale 1ns/1ps

module axi_register_rd
    import axi_rd_proto_pkg::*;
    import axi_rd_cfg_pkg::*;
#(
    parameter int DATA_WIDTH = DEF_DATA_W,
    parameter int ADDR_WIDTH = DEF_ADDR_W,
    parameter int ID_WIDTH   = DEF_ID_W
) (
    input  logic                  clk,
    input  logic                  rst,

    // upstream manager side
    input  logic [ID_WIDTH-1:0]   s_arid,
    input  logic [ADDR_WIDTH-1:0] s_araddr,
    input  logic [LEN_W-1:0]      s_arlen,
    input  logic [SIZE_W-1:0]     s_arsize,
    input  burst_t                s_arburst,
    input  logic                  s_arlock,
    input  logic [CACHE_W-1:0]    s_arcache,
    input  logic [PROT_W-1:0]     s_arprot,
    input  logic [QOS_W-1:0]      s_arqos,
    input  logic [REGION_W-1:0]   s_arregion,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output logic [ID_WIDTH-1:0]   s_rid,
    output logic [DATA_WIDTH-1:0] s_rdata,
    output resp_t                 s_rresp,
    output logic                  s_rlast,
    output logic                  s_rvalid,
    input  logic                  s_rready,

    // downstream subordinate side
    output logic [ID_WIDTH-1:0]   m_arid,
    output logic [ADDR_WIDTH-1:0] m_araddr,
    output logic [LEN_W-1:0]      m_arlen,
    output logic [SIZE_W-1:0]     m_arsize,
    output burst_t                m_arburst,
    output logic                  m_arlock,
    output logic [CACHE_W-1:0]    m_arcache,
    output logic [PROT_W-1:0]     m_arprot,
    output logic [QOS_W-1:0]      m_arqos,
    output logic [REGION_W-1:0]   m_arregion,
    output logic                  m_arvalid,
    input  logic                  m_arready,
    input  logic [ID_WIDTH-1:0]   m_rid,
    input  logic [DATA_WIDTH-1:0] m_rdata,
    input  resp_t                 m_rresp,
    input  logic                  m_rlast,
    input  logic                  m_rvalid,
    output logic                  m_rready
);

    // port names match the slices one to one
    // two independent channels, no ordering between them

    // address channel, one entry with a bubble
    axi_ar_reg #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) ar_reg_i (
        .*
    );

    // data channel, two-entry skid buffer
    axi_r_skid #(
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) r_skid_i (
        .*
    );

endmodule
